// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = core_tb
RTL_TOP   = core
FILELIST  = core.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL TESTS PASSED

SRCS      = $(shell grep -v '^+' $(FILELIST))
RTL_FILES = $(shell grep '^design/' $(FILELIST))
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

// File: core.f
design/common_pkg.sv
design/pipe_pkg.sv
design/fetch.sv
design/decode.sv
design/regfile.sv
design/execute.sv
design/memory.sv
design/core.sv
sim/bus_model.sv
sim/core_tb.sv

// File: design/common_pkg.sv
package common_pkg;

	typedef logic [63:0] word_t;
	typedef logic [63:0] addr_t;
	typedef logic [31:0] u32;
	typedef logic [4:0] creg_addr_t;

	localparam addr_t PCINIT = 64'h0000_0000_8000_0000;

	typedef struct packed {
		logic  valid;
		addr_t addr;
	} ibus_req_t;

	typedef struct packed {
		logic data_ok;
		u32   data; // one instruction
	} ibus_resp_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		word_t wdata;
	} dbus_req_t;

	typedef struct packed {
		logic  data_ok;
		word_t data;
	} dbus_resp_t;

endpackage

// File: design/core.sv
`timescale 1ns/100ps

module core (
	input  logic                   clk,
	input  logic                   reset,
	output common_pkg::ibus_req_t  ireq,
	input  common_pkg::ibus_resp_t iresp,
	output common_pkg::dbus_req_t  dreq,
	input  common_pkg::dbus_resp_t dresp
);
	import common_pkg::*;
	import pipe_pkg::*;

	logic         stall;
	fetch_data_t  data_f;
	decode_data_t data_d;
	exec_data_t   data_e;
	creg_addr_t   ra1;
	creg_addr_t   ra2;
	word_t        rd1;
	word_t        rd2;
	logic         wvalid;
	creg_addr_t   wa;
	word_t        wd;
	logic         fwd_valid;
	creg_addr_t   fwd_dst;
	word_t        fwd_data;

	// any bus still waiting freezes the whole pipe
	assign stall = (ireq.valid && !iresp.data_ok) || (dreq.valid && !dresp.data_ok);

	fetch u_fetch (
		.clk    (clk),
		.reset  (reset),
		.stall  (stall),
		.ireq   (ireq),
		.iresp  (iresp),
		.data_f (data_f)
	);

	decode u_decode (
		.clk    (clk),
		.reset  (reset),
		.stall  (stall),
		.data_f (data_f),
		.ra1    (ra1),
		.ra2    (ra2),
		.rd1    (rd1),
		.rd2    (rd2),
		.data_d (data_d)
	);

	regfile u_regfile (
		.clk    (clk),
		.reset  (reset),
		.wvalid (wvalid),
		.wa     (wa),
		.ra1    (ra1),
		.ra2    (ra2),
		.wd     (wd),
		.rd1    (rd1),
		.rd2    (rd2)
	);

	execute u_execute (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.data_d    (data_d),
		.fwd_valid (fwd_valid),
		.fwd_dst   (fwd_dst),
		.fwd_data  (fwd_data),
		.data_e    (data_e)
	);

	memory u_memory (
		.clk       (clk),
		.reset     (reset),
		.data_e    (data_e),
		.dreq      (dreq),
		.dresp     (dresp),
		.wvalid    (wvalid),
		.wa        (wa),
		.wd        (wd),
		.fwd_valid (fwd_valid),
		.fwd_dst   (fwd_dst),
		.fwd_data  (fwd_data)
	);

endmodule

// File: design/decode.sv
`timescale 1ns/100ps

module decode (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  pipe_pkg::fetch_data_t  data_f,
	output common_pkg::creg_addr_t ra1,
	output common_pkg::creg_addr_t ra2,
	input  common_pkg::word_t      rd1,
	input  common_pkg::word_t      rd2,
	output pipe_pkg::decode_data_t data_d
);
	import common_pkg::*;
	import pipe_pkg::*;

	u32         instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	ctl_t       ctl;
	word_t      imm;

	assign instr = data_f.raw_instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign ra1 = instr[19:15];
	assign ra2 = instr[24:20];

	always_comb begin
		ctl = '0;
		ctl.op = OP_NOP;
		ctl.alu_op = ALU_ADD;
		imm = {{52{instr[31]}}, instr[31:20]}; // I-type
		case (opcode)
			7'b0010011: begin
				if (funct3 == 3'b000) begin
					ctl.op = OP_ADDI;
					ctl.use_imm = 1'b1;
				end
			end
			7'b0110011: begin
				case ({funct7, funct3})
					10'b0000000_000: begin
						ctl.op = OP_ADD;
					end
					10'b0100000_000: begin
						ctl.op = OP_SUB;
						ctl.alu_op = ALU_SUB;
					end
					10'b0000000_111: begin
						ctl.op = OP_AND;
						ctl.alu_op = ALU_AND;
					end
					10'b0000000_110: begin
						ctl.op = OP_OR;
						ctl.alu_op = ALU_OR;
					end
					10'b0000000_100: begin
						ctl.op = OP_XOR;
						ctl.alu_op = ALU_XOR;
					end
					default: ;
				endcase
			end
			7'b0110111: begin
				ctl.op = OP_LUI;
				ctl.alu_op = ALU_PASSB;
				ctl.use_imm = 1'b1;
				imm = {{32{instr[31]}}, instr[31:12], 12'b0};
			end
			7'b0000011: begin
				if (funct3 == 3'b011) begin
					ctl.op = OP_LD;
					ctl.use_imm = 1'b1;
					ctl.mem_read = 1'b1;
				end
			end
			7'b0100011: begin
				if (funct3 == 3'b011) begin
					ctl.op = OP_SD;
					ctl.use_imm = 1'b1;
					ctl.mem_write = 1'b1;
				end
				imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
			end
			default: ;
		endcase
		ctl.reg_write = (ctl.op != OP_NOP) && (ctl.op != OP_SD);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_d.valid <= 1'b0;
		end else if (!stall) begin
			data_d.valid <= data_f.valid;
			data_d.pc <= data_f.pc;
			data_d.ctl <= ctl;
			data_d.dst <= instr[11:7];
			data_d.ra1 <= ra1;
			data_d.ra2 <= ra2;
			data_d.rd1 <= rd1;
			data_d.rd2 <= rd2;
			data_d.imm <= imm;
		end
	end

endmodule

// File: design/execute.sv
`timescale 1ns/100ps

module execute (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  pipe_pkg::decode_data_t data_d,
	input  logic                   fwd_valid,
	input  common_pkg::creg_addr_t fwd_dst,
	input  common_pkg::word_t      fwd_data,
	output pipe_pkg::exec_data_t   data_e
);
	import common_pkg::*;
	import pipe_pkg::*;

	word_t src1;
	word_t src2;
	word_t opb;
	word_t result;

	// take the memory stage's result when it targets this source
	function automatic word_t fwd_sel(input creg_addr_t ra, input word_t rd);
		if (fwd_valid && fwd_dst != '0 && fwd_dst == ra) begin
			return fwd_data;
		end
		return rd;
	endfunction

	assign src1 = fwd_sel(data_d.ra1, data_d.rd1);
	assign src2 = fwd_sel(data_d.ra2, data_d.rd2);
	assign opb = data_d.ctl.use_imm ? data_d.imm : src2;

	always_comb begin
		case (data_d.ctl.alu_op)
			ALU_SUB:   result = src1 - opb;
			ALU_AND:   result = src1 & opb;
			ALU_OR:    result = src1 | opb;
			ALU_XOR:   result = src1 ^ opb;
			ALU_PASSB: result = opb;
			default:   result = src1 + opb;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data_e.valid <= 1'b0;
		end else if (!stall) begin
			data_e.valid <= data_d.valid;
			data_e.pc <= data_d.pc;
			data_e.ctl <= data_d.ctl;
			data_e.dst <= data_d.dst;
			data_e.aluout <= result;
			data_e.storedata <= src2; // sd data, already forwarded
		end
	end

endmodule

// File: design/fetch.sv
`timescale 1ns/100ps

module fetch (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	output common_pkg::ibus_req_t  ireq,
	input  common_pkg::ibus_resp_t iresp,
	output pipe_pkg::fetch_data_t  data_f
);
	import common_pkg::*;

	addr_t pc;
	logic  active;
	logic  fetch_done;

	assign ireq.valid = active;
	assign ireq.addr = pc;
	assign fetch_done = ireq.valid && iresp.data_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			pc <= PCINIT;
		end else begin
			active <= 1'b1; // start fetching once out of reset
			if (fetch_done && !stall) begin
				pc <= pc + 64'd4;
			end
		end
	end

	// done but stalled downstream means the same pc is asked for again
	always_ff @(posedge clk) begin
		if (reset) begin
			data_f.valid <= 1'b0;
		end else if (!stall) begin
			data_f.valid <= fetch_done;
			data_f.pc <= pc;
			data_f.raw_instr <= iresp.data;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		ireq.valid && !iresp.data_ok |=> ireq.valid && $stable(ireq.addr));

endmodule

// File: design/memory.sv
`timescale 1ns/100ps

module memory (
	input  logic                   clk,
	input  logic                   reset,
	input  pipe_pkg::exec_data_t   data_e,
	output common_pkg::dbus_req_t  dreq,
	input  common_pkg::dbus_resp_t dresp,
	output logic                   wvalid,
	output common_pkg::creg_addr_t wa,
	output common_pkg::word_t      wd,
	output logic                   fwd_valid,
	output common_pkg::creg_addr_t fwd_dst,
	output common_pkg::word_t      fwd_data
);
	import common_pkg::*;

	logic  mem_op;
	logic  done_now;
	logic  served_q;
	addr_t served_pc;
	word_t load_q;
	logic  served;
	word_t result;

	// an access that finished while fetch still stalls must not go out twice
	assign served = served_q && served_pc == data_e.pc;
	assign mem_op = data_e.ctl.mem_read || data_e.ctl.mem_write;

	assign dreq.valid = data_e.valid && mem_op && !served;
	assign dreq.write = data_e.ctl.mem_write;
	assign dreq.addr = data_e.aluout;
	assign dreq.wdata = data_e.storedata;
	assign done_now = dreq.valid && dresp.data_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			served_q <= 1'b0;
		end else if (done_now) begin
			served_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (done_now) begin
			served_pc <= data_e.pc;
			load_q <= dresp.data; // kept for the forward path while held
		end
	end

	always_comb begin
		if (!data_e.ctl.mem_read) begin
			result = data_e.aluout;
		end else if (served) begin
			result = load_q;
		end else begin
			result = dresp.data;
		end
	end

	assign wvalid = data_e.valid && data_e.ctl.reg_write &&
		(!data_e.ctl.mem_read || served || done_now);
	assign wa = data_e.dst;
	assign wd = result;

	assign fwd_valid = wvalid;
	assign fwd_dst = wa;
	assign fwd_data = wd;

	assert property (@(posedge clk) disable iff (reset)
		dreq.valid && !dresp.data_ok |=> dreq.valid && $stable(dreq.write) &&
		$stable(dreq.addr) && $stable(dreq.wdata));

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

	import common_pkg::*;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_LUI,
		OP_LD,
		OP_SD
	} op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSB // b straight through, for lui
	} alu_op_t;

	typedef struct packed {
		op_t     op;
		alu_op_t alu_op;
		logic    use_imm;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
	} ctl_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		u32    raw_instr;
	} fetch_data_t;

	typedef struct packed {
		logic       valid;
		addr_t      pc;
		ctl_t       ctl;
		creg_addr_t dst;
		creg_addr_t ra1;
		creg_addr_t ra2;
		word_t      rd1;
		word_t      rd2;
		word_t      imm;
	} decode_data_t;

	typedef struct packed {
		logic       valid;
		addr_t      pc;
		ctl_t       ctl;
		creg_addr_t dst;
		word_t      aluout; // also the ld/sd address
		word_t      storedata;
	} exec_data_t;

endpackage

// File: design/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   wvalid,
	input  common_pkg::creg_addr_t wa,
	input  common_pkg::creg_addr_t ra1,
	input  common_pkg::creg_addr_t ra2,
	input  common_pkg::word_t      wd,
	output common_pkg::word_t      rd1,
	output common_pkg::word_t      rd2
);
	import common_pkg::*;

	word_t regs [31:0];

	// write-first, so a same-cycle write shows up on the read port
	function automatic word_t read_port(input creg_addr_t ra);
		if (wvalid && wa != '0 && wa == ra) begin
			return wd;
		end
		return regs[ra];
	endfunction

	assign rd1 = read_port(ra1);
	assign rd2 = read_port(ra2);

	always_ff @(posedge clk) begin
		if (reset) begin
			regs[0] <= '0;
		end else if (wvalid && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

// File: sim/bus_model.sv
`timescale 1ns/100ps

module bus_model (
	input  logic                   clk,
	input  common_pkg::ibus_req_t  ireq,
	output common_pkg::ibus_resp_t iresp,
	input  common_pkg::dbus_req_t  dreq,
	output common_pkg::dbus_resp_t dresp,
	output common_pkg::dbus_req_t  store_log,
	output logic [7:0]             prog_len
);
	import common_pkg::*;

	localparam int NPROG = 24;
	localparam u32 NOP = 32'h0000_0013; // addi x0, x0, 0

	u32    prog [NPROG];
	word_t dmem [addr_t];
	int    seed;
	int    iwait;
	int    dwait;
	logic  ibusy;
	logic  dbusy;

	assign prog_len = 8'(NPROG);

	function automatic u32 addi_instr(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic u32 rtype_instr(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, rs1, rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic u32 lui_instr(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic u32 ld_instr(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b011, rd, 7'b0000011};
	endfunction

	function automatic u32 sd_instr(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
	endfunction

	// past the end of the program the core just runs nops
	function automatic u32 fetch_word(input addr_t a);
		addr_t off;
		off = a - PCINIT;
		if (off < 64'(NPROG * 4)) begin
			return prog[off[6:2]];
		end
		return NOP;
	endfunction

	function automatic word_t read_word(input addr_t a);
		if (dmem.exists(a)) begin
			return dmem[a];
		end
		return {a[31:0] ^ 32'h0bad_f00d, a[63:32]}; // untouched location
	endfunction

	initial begin
		seed = 32'hdc547e6d;
		ibusy = 1'b0;
		dbusy = 1'b0;
		iresp = '0;
		dresp = '0;
		store_log = '0;
		prog[0] = lui_instr(5'd10, 20'h00010); // x10 = data base
		prog[1] = addi_instr(5'd1, 5'd0, 12'd100);
		prog[2] = addi_instr(5'd2, 5'd0, 12'hff9); // -7
		prog[3] = rtype_instr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2); // add
		prog[4] = sd_instr(5'd3, 5'd10, 12'd0);
		prog[5] = rtype_instr(7'h20, 3'b000, 5'd4, 5'd1, 5'd2); // sub
		prog[6] = rtype_instr(7'h00, 3'b111, 5'd5, 5'd1, 5'd2); // and
		prog[7] = rtype_instr(7'h00, 3'b110, 5'd6, 5'd1, 5'd2); // or
		prog[8] = rtype_instr(7'h00, 3'b100, 5'd7, 5'd1, 5'd2); // xor
		prog[9] = sd_instr(5'd4, 5'd10, 12'd8);
		prog[10] = sd_instr(5'd5, 5'd10, 12'd16);
		prog[11] = sd_instr(5'd6, 5'd10, 12'd24);
		prog[12] = sd_instr(5'd7, 5'd10, 12'd32);
		prog[13] = lui_instr(5'd8, 20'hfedcb);
		prog[14] = sd_instr(5'd8, 5'd10, 12'd40);
		prog[15] = addi_instr(5'd11, 5'd1, 12'd5);
		prog[16] = rtype_instr(7'h00, 3'b000, 5'd12, 5'd11, 5'd11); // distance one
		prog[17] = rtype_instr(7'h20, 3'b000, 5'd13, 5'd12, 5'd11); // one and two
		prog[18] = sd_instr(5'd13, 5'd10, 12'd48);
		prog[19] = ld_instr(5'd17, 5'd10, 12'd8);
		prog[20] = addi_instr(5'd18, 5'd17, 12'd1); // load use
		prog[21] = sd_instr(5'd18, 5'd10, 12'd56);
		prog[22] = addi_instr(5'd0, 5'd0, 12'd55);
		prog[23] = sd_instr(5'd0, 5'd10, 12'd64);
	end

	// each request waits 0 to 3 cycles, drawn when it first shows up
	always @(negedge clk) begin
		store_log <= '0;
		if (!ireq.valid) begin
			iresp <= '0;
			ibusy = 1'b0;
		end else begin
			if (!ibusy) begin
				iwait = $random(seed) & 3;
				ibusy = 1'b1;
			end
			if (iwait == 0) begin
				iresp.data_ok <= 1'b1;
				iresp.data <= fetch_word(ireq.addr);
				ibusy = 1'b0;
			end else begin
				iresp.data_ok <= 1'b0;
				iwait = iwait - 1;
			end
		end
		if (!dreq.valid) begin
			dresp <= '0;
			dbusy = 1'b0;
		end else begin
			if (!dbusy) begin
				dwait = $random(seed) & 3;
				dbusy = 1'b1;
			end
			if (dwait == 0) begin
				dresp.data_ok <= 1'b1;
				dbusy = 1'b0;
				if (dreq.write) begin
					dmem[dreq.addr] = dreq.wdata;
					store_log <= dreq;
				end else begin
					dresp.data <= read_word(dreq.addr);
				end
			end else begin
				dresp.data_ok <= 1'b0;
				dwait = dwait - 1;
			end
		end
	end

endmodule

// File: sim/core_tb.sv
`timescale 1ns/100ps

module core_tb;
	import common_pkg::*;

	logic       clk;
	logic       reset;
	ibus_req_t  ireq;
	ibus_resp_t iresp;
	dbus_req_t  dreq;
	dbus_resp_t dresp;
	dbus_req_t  store_log;
	logic [7:0] prog_len;

	dbus_req_t store_q [$];
	string     row_name [$];
	addr_t     row_addr [$];
	word_t     row_data [$];
	int        cycles;
	int        limit;
	int        pass_count;
	int        fail_count;

	core u_dut (
		.clk   (clk),
		.reset (reset),
		.ireq  (ireq),
		.iresp (iresp),
		.dreq  (dreq),
		.dresp (dresp)
	);

	bus_model u_bus (
		.clk       (clk),
		.ireq      (ireq),
		.iresp     (iresp),
		.dreq      (dreq),
		.dresp     (dresp),
		.store_log (store_log),
		.prog_len  (prog_len)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign limit = int'(prog_len) * 4 * 5; // 4 cycles per instr, 5x for stalls

	always @(posedge clk) begin
		if (store_log.valid) begin
			store_q.push_back(store_log);
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			cycles <= 0;
		end else if (cycles >= limit) begin
			$display("timeout: run stopped after %0d cycles, stores missing", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			cycles <= cycles + 1;
		end
	end

	task automatic add_row(input string name, input addr_t addr, input word_t data);
		row_name.push_back(name);
		row_addr.push_back(addr);
		row_data.push_back(data);
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual,
		output logic ok);
		ok = (expected === actual);
		if (!ok) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic record_result(input string name, input logic ok);
		if (ok) begin
			pass_count++;
			$display("ok   %s", name);
		end else begin
			fail_count++;
		end
	endtask

	initial begin
		dbus_req_t st;
		logic      ok;
		logic      ok_addr;
		logic      ok_data;
		addr_t     end_addr;
		pass_count = 0;
		fail_count = 0;
		reset = 1'b1;
		// expected stores, in program order
		add_row("add", 64'h1_0000, 64'd93);
		add_row("sub", 64'h1_0008, 64'd107);
		add_row("and", 64'h1_0010, 64'd96);
		add_row("or", 64'h1_0018, 64'hffff_ffff_ffff_fffd);
		add_row("xor", 64'h1_0020, 64'hffff_ffff_ffff_ff9d);
		add_row("lui", 64'h1_0028, 64'hffff_ffff_fedc_b000);
		add_row("forward chain", 64'h1_0030, 64'd105);
		add_row("load use", 64'h1_0038, 64'd108);
		add_row("x0 stays zero", 64'h1_0040, 64'd0);

		ok = 1'b1;
		repeat (4) begin
			@(negedge clk);
			if (ireq.valid !== 1'b0) begin
				$display("reset: instruction request raised while reset is held");
				ok = 1'b0;
			end
		end
		reset = 1'b0;
		@(negedge clk);
		if (ireq.valid !== 1'b1 || ireq.addr !== PCINIT) begin
			$display("reset: first fetch after reset is not a request at the reset pc");
			ok = 1'b0;
		end
		record_result("reset", ok);

		for (int i = 0; i < row_name.size(); i++) begin
			while (store_q.size() == 0) begin
				@(negedge clk);
			end
			st = store_q.pop_front();
			check_value({row_name[i], " address"}, row_addr[i], st.addr, ok_addr);
			check_value({row_name[i], " data"}, row_data[i], st.wdata, ok_data);
			record_result(row_name[i], ok_addr && ok_data);
		end

		// once fetch is well past the program every store has retired
		end_addr = PCINIT + 64'(prog_len) * 64'd4 + 64'd32;
		while (ireq.addr < end_addr) begin
			@(negedge clk);
		end
		if (store_q.size() != 0) begin
			$display("store count: %0d stores beyond the expected list", store_q.size());
			fail_count++;
		end else begin
			record_result("store count", 1'b1);
		end

		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
